/* sim.f */
hdl/shuffle_pkg.sv
hdl/walker_cfg_if.sv
hdl/shuffle_cmd_decode.sv
hdl/shuffle_ctrl.sv
hdl/stride_walker.sv
hdl/bank_router.sv
hdl/simd_data_shuffler.sv
testbench/simd_data_shuffler_assert.sv
testbench/tb_simd_data_shuffler.sv

/* Bender.yml */
package:
  name: simd_data_shuffler

sources:
  - hdl/shuffle_pkg.sv
  - hdl/walker_cfg_if.sv
  - hdl/shuffle_cmd_decode.sv
  - hdl/shuffle_ctrl.sv
  - hdl/stride_walker.sv
  - hdl/bank_router.sv
  - hdl/simd_data_shuffler.sv
  - target: test
    files:
      - testbench/simd_data_shuffler_assert.sv
      - testbench/tb_simd_data_shuffler.sv

/* testbench/tb_simd_data_shuffler.sv */
// ==================================================
// testbench for the SIMD data shuffler: VMEM models,
// permute jobs and word by word result checks
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_simd_data_shuffler;
    import shuffle_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;
    // 4 * (N + 10) summed over the four jobs
    localparam int TIMEOUT_CYCLES = 4 * ((12 + 10) + (12 + 10) + (6 + 10) + (4 + 10));

    typedef struct packed {
        logic [7:0]         rd_base;
        logic [7:0]         rd_s0;
        logic [7:0]         rd_s1;
        logic [7:0]         wr_base;
        logic [7:0]         wr_s0;
        logic [7:0]         wr_s1;
        logic [7:0]         cnt0;
        logic [7:0]         cnt1;
        logic [NS_ID_W-1:0] src;
        logic [NS_ID_W-1:0] dst;
        logic               mode;
    } job_t;

    logic                               clk;
    logic                               reset;
    logic [OPCODE_W-1:0]                opcode;
    logic [FN_W-1:0]                    fn;
    logic [NS_ID_W-1:0]                 dest_ns_id;
    logic [NS_INDEX_W-1:0]              dest_ns_index_id;
    logic [NS_ID_W-1:0]                 src1_ns_id;
    logic [NS_INDEX_W-1:0]              src1_ns_index_id;
    logic [NS_ID_W-1:0]                 src2_ns_id;
    logic [NS_INDEX_W-1:0]              src2_ns_index_id;
    logic                               data_shuffle_done;
    logic [NUM_LANES-1:0]               vmem1_write_req;
    logic [NUM_LANES-1:0][ADDR_W-1:0]   vmem1_write_addr;
    logic [NUM_LANES-1:0][DATA_W-1:0]   vmem1_write_data;
    logic [NUM_LANES-1:0]               vmem1_read_req;
    logic [NUM_LANES-1:0][ADDR_W-1:0]   vmem1_read_addr;
    logic [NUM_LANES-1:0][DATA_W-1:0]   vmem1_read_data;
    logic [NUM_LANES-1:0]               vmem2_write_req;
    logic [NUM_LANES-1:0][ADDR_W-1:0]   vmem2_write_addr;
    logic [NUM_LANES-1:0][DATA_W-1:0]   vmem2_write_data;
    logic [NUM_LANES-1:0]               vmem2_read_req;
    logic [NUM_LANES-1:0][ADDR_W-1:0]   vmem2_read_addr;
    logic [NUM_LANES-1:0][DATA_W-1:0]   vmem2_read_data;

    logic [DATA_W-1:0] vmem1_mem [NUM_LANES][DEPTH];
    logic [DATA_W-1:0] vmem2_mem [NUM_LANES][DEPTH];
    logic [DATA_W-1:0] src_snap [NUM_LANES][DEPTH];

    int unsigned seed_val;
    int          cycle_count;
    int          error_count;
    int          check_count;
    int          rd_cycles;
    int          wr_cycles;
    int          done_pulses;
    logic        idle_check;
    job_t        job;

    simd_data_shuffler #(
        .NUM_LANES(NUM_LANES), .DATA_W(DATA_W), .ADDR_W(ADDR_W)
    ) simd_data_shuffler_i (
        .clk(clk), .reset(reset), .opcode(opcode), .fn(fn),
        .dest_ns_id(dest_ns_id), .dest_ns_index_id(dest_ns_index_id),
        .src1_ns_id(src1_ns_id), .src1_ns_index_id(src1_ns_index_id),
        .src2_ns_id(src2_ns_id), .src2_ns_index_id(src2_ns_index_id),
        .data_shuffle_done(data_shuffle_done),
        .vmem1_write_req(vmem1_write_req), .vmem1_write_addr(vmem1_write_addr),
        .vmem1_write_data(vmem1_write_data), .vmem1_read_req(vmem1_read_req),
        .vmem1_read_addr(vmem1_read_addr), .vmem1_read_data(vmem1_read_data),
        .vmem2_write_req(vmem2_write_req), .vmem2_write_addr(vmem2_write_addr),
        .vmem2_write_data(vmem2_write_data), .vmem2_read_req(vmem2_read_req),
        .vmem2_read_addr(vmem2_read_addr), .vmem2_read_data(vmem2_read_data)
    );

    always #2 clk = ~clk;

    // ==================================================
    // VMEM models, read data one cycle after the request
    // ==================================================
    always @(posedge clk) begin
        for (int n = 0; n < NUM_LANES; n++) begin
            if (vmem1_read_req[n]) begin
                vmem1_read_data[n] <= vmem1_mem[n][vmem1_read_addr[n]];
            end
            if (vmem2_read_req[n]) begin
                vmem2_read_data[n] <= vmem2_mem[n][vmem2_read_addr[n]];
            end
            if (vmem1_write_req[n]) begin
                vmem1_mem[n][vmem1_write_addr[n]] <= vmem1_write_data[n];
            end
            if (vmem2_write_req[n]) begin
                vmem2_mem[n][vmem2_write_addr[n]] <= vmem2_write_data[n];
            end
        end
    end

    // request and done activity, plus the quiet check before the first start
    always @(posedge clk) begin
        if (!reset) begin
            if ((|vmem1_read_req) || (|vmem2_read_req)) begin
                rd_cycles++;
            end
            if ((|vmem1_write_req) || (|vmem2_write_req)) begin
                wr_cycles++;
            end
            if (data_shuffle_done) begin
                done_pulses++;
            end
            if (idle_check && ((|vmem1_read_req) || (|vmem2_read_req) ||
                    (|vmem1_write_req) || (|vmem2_write_req) || data_shuffle_done)) begin
                $display("error at %0t: request or done raised before the first start", $time);
                error_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, a job never finished", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // expected word for element e on destination lane n
    function automatic logic [DATA_W-1:0] expected_word(input job_t j, input int e, input int n);
        int i0;
        int i1;
        int addr;
        int src_lane;
        i0       = e % j.cnt0;
        i1       = e / j.cnt0;
        addr     = (j.rd_base + i0 * j.rd_s0 + i1 * j.rd_s1) % DEPTH;
        src_lane = j.mode ? (n + e) % NUM_LANES : n;
        return src_snap[src_lane][addr];
    endfunction

    task automatic send_instr(input logic [FN_W-1:0] f, input logic [NS_ID_W-1:0] dst_id,
                              input logic [NS_INDEX_W-1:0] dst_idx, input logic [CFG_W-1:0] value);
        @(negedge clk);
        opcode           = OP_PERMUTE;
        fn               = f;
        dest_ns_id       = dst_id;
        dest_ns_index_id = dst_idx;
        {src1_ns_id, src1_ns_index_id, src2_ns_id, src2_ns_index_id} = value;
        @(negedge clk);
        opcode = '0;
    endtask

    // side 0 is the read walker, side 1 the write walker
    task automatic configure_side(input logic [NS_ID_W-1:0] side, input logic [7:0] base,
                                  input logic [7:0] s0, input logic [7:0] s1,
                                  input logic [7:0] c0, input logic [7:0] c1);
        send_instr(FN_SET_BASE, side, 5'd0, {8'd0, base});
        send_instr(FN_SET_STRIDE, side, 5'd0, {8'd0, s0});
        send_instr(FN_SET_STRIDE, side, 5'd1, {8'd0, s1});
        send_instr(FN_SET_ITER, side, 5'd0, {8'd0, c0});
        send_instr(FN_SET_ITER, side, 5'd1, {8'd0, c1});
    endtask

    task automatic drive_start(input job_t j);
        opcode           = OP_PERMUTE;
        fn               = FN_START;
        dest_ns_id       = j.dst;
        dest_ns_index_id = '0;
        src1_ns_id       = j.src;
        src1_ns_index_id = '0;
        src2_ns_id       = '0;
        src2_ns_index_id = {4'b0000, j.mode};
    endtask

    task automatic run_job(input job_t j, input logic busy_start);
        int   n_elem;
        int   lat;
        int   rd0;
        int   wr0;
        int   d0;
        int   exp_rd;
        int   waddr;
        logic seen;
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] exp;
        n_elem = j.cnt0 * j.cnt1;
        exp_rd = (j.src == VMEM1_ID || j.src == VMEM2_ID) ? n_elem : 0;
        configure_side(3'd0, j.rd_base, j.rd_s0, j.rd_s1, j.cnt0, j.cnt1);
        configure_side(3'd1, j.wr_base, j.wr_s0, j.wr_s1, j.cnt0, j.cnt1);
        for (int n = 0; n < NUM_LANES; n++) begin
            for (int a = 0; a < DEPTH; a++) begin
                src_snap[n][a] = (j.src == VMEM1_ID) ? vmem1_mem[n][a] : vmem2_mem[n][a];
            end
        end
        rd0 = rd_cycles;
        wr0 = wr_cycles;
        d0  = done_pulses;
        @(negedge clk);
        idle_check = 1'b0;
        drive_start(j);
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < n_elem + 20) begin
            @(negedge clk);
            lat++;
            opcode = '0;
            if (data_shuffle_done) begin
                seen = 1'b1;
            end else if (busy_start && lat == 2) begin
                // second start while the first job runs
                drive_start(j);
            end
        end
        check_count += 4;
        if (!seen) begin
            $display("error at %0t: data_shuffle_done never arrived", $time);
            error_count++;
        end else if (lat != n_elem + 3) begin
            $display("[FAIL] t=%0t done_latency: got %0d expected %0d", $time, lat, n_elem + 3);
            error_count++;
        end
        repeat (4) @(negedge clk);
        if (done_pulses - d0 != 1) begin
            $display("[FAIL] t=%0t done_pulses: got %0d expected 1", $time, done_pulses - d0);
            error_count++;
        end
        if (rd_cycles - rd0 != exp_rd) begin
            $display("[FAIL] t=%0t read_req_cycles: got %0d expected %0d",
                     $time, rd_cycles - rd0, exp_rd);
            error_count++;
        end
        if (wr_cycles - wr0 != n_elem) begin
            $display("[FAIL] t=%0t write_req_cycles: got %0d expected %0d",
                     $time, wr_cycles - wr0, n_elem);
            error_count++;
        end
        if (exp_rd != 0) begin
            for (int e = 0; e < n_elem; e++) begin
                waddr = (j.wr_base + (e % j.cnt0) * j.wr_s0 + (e / j.cnt0) * j.wr_s1) % DEPTH;
                for (int n = 0; n < NUM_LANES; n++) begin
                    got = (j.dst == VMEM1_ID) ? vmem1_mem[n][waddr] : vmem2_mem[n][waddr];
                    exp = expected_word(j, e, n);
                    check_count++;
                    if (got !== exp) begin
                        $display("[FAIL] t=%0t vmem%0d_mem[%0d][%0h]: got %h expected %h",
                                 $time, j.dst - 1, n, waddr, got, exp);
                        error_count++;
                    end
                end
            end
        end
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        clk              = 1'b0;
        reset            = 1'b1;
        opcode           = '0;
        fn               = '0;
        dest_ns_id       = '0;
        dest_ns_index_id = '0;
        src1_ns_id       = '0;
        src1_ns_index_id = '0;
        src2_ns_id       = '0;
        src2_ns_index_id = '0;
        vmem1_read_data  = '0;
        vmem2_read_data  = '0;
        idle_check       = 1'b1;
        seed_val         = $urandom(20);
        for (int n = 0; n < NUM_LANES; n++) begin
            for (int a = 0; a < DEPTH; a++) begin
                vmem1_mem[n][a] = $urandom;
                vmem2_mem[n][a] = $urandom;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (5) @(negedge clk);

        // 4x3 plain copy, VMEM1 to VMEM2
        job = '{rd_base: 8'h10, rd_s0: 8'd1, rd_s1: 8'd4, wr_base: 8'h40, wr_s0: 8'd1,
                wr_s1: 8'd4, cnt0: 8'd4, cnt1: 8'd3, src: VMEM1_ID, dst: VMEM2_ID, mode: 1'b0};
        run_job(job, 1'b0);
        // transpose by swapped strides with lane rotation, VMEM2 to VMEM1
        job = '{rd_base: 8'h20, rd_s0: 8'd1, rd_s1: 8'd4, wr_base: 8'h80, wr_s0: 8'd3,
                wr_s1: 8'd1, cnt0: 8'd4, cnt1: 8'd3, src: VMEM2_ID, dst: VMEM1_ID, mode: 1'b1};
        run_job(job, 1'b0);
        job = '{rd_base: 8'h60, rd_s0: 8'd2, rd_s1: 8'd8, wr_base: 8'ha0, wr_s0: 8'd1,
                wr_s1: 8'd3, cnt0: 8'd3, cnt1: 8'd2, src: VMEM1_ID, dst: VMEM2_ID, mode: 1'b1};
        run_job(job, 1'b1);
        // unknown source id
        job = '{rd_base: 8'h00, rd_s0: 8'd1, rd_s1: 8'd2, wr_base: 8'hc0, wr_s0: 8'd1,
                wr_s1: 8'd2, cnt0: 8'd2, cnt1: 8'd2, src: 3'd5, dst: VMEM2_ID, mode: 1'b0};
        run_job(job, 1'b0);

        // bound protocol assertions count as errors too
        error_count += simd_data_shuffler_i.simd_data_shuffler_assert_i.fail_count;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/simd_data_shuffler_assert.sv */
// ==================================================
// protocol assertions bound to the shuffler top
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module simd_data_shuffler_assert #(
    parameter int NUM_LANES = shuffle_pkg::NUM_LANES
) (
    input logic                 clk,
    input logic                 reset,
    input logic                 data_shuffle_done,
    input logic [NUM_LANES-1:0] vmem1_read_req,
    input logic [NUM_LANES-1:0] vmem2_read_req,
    input logic [NUM_LANES-1:0] vmem1_write_req,
    input logic [NUM_LANES-1:0] vmem2_write_req
);

    logic any_req;
    // number of property failures so far
    int   fail_count;

    assign any_req = (|vmem1_read_req) || (|vmem2_read_req) ||
                     (|vmem1_write_req) || (|vmem2_write_req);

    done_single_cycle: assert property (
        @(posedge clk) disable iff (reset) data_shuffle_done |=> !data_shuffle_done
    ) else begin
        $error("data_shuffle_done held longer than one cycle");
        fail_count++;
    end

    // one destination per job
    single_write_target: assert property (
        @(posedge clk) disable iff (reset) !((|vmem1_write_req) && (|vmem2_write_req))
    ) else begin
        $error("both VMEMs write-requested in the same cycle");
        fail_count++;
    end

    quiet_at_done: assert property (
        @(posedge clk) disable iff (reset) data_shuffle_done |-> !any_req
    ) else begin
        $error("VMEM request raised while done is high");
        fail_count++;
    end

endmodule

bind simd_data_shuffler simd_data_shuffler_assert #(
    .NUM_LANES(NUM_LANES)
) simd_data_shuffler_assert_i (
    .clk(clk), .reset(reset), .data_shuffle_done(data_shuffle_done),
    .vmem1_read_req(vmem1_read_req), .vmem2_read_req(vmem2_read_req),
    .vmem1_write_req(vmem1_write_req), .vmem2_write_req(vmem2_write_req)
);

`default_nettype wire

/* hdl/simd_data_shuffler.sv */
// ==================================================
// SIMD data shuffler top: moves, transposes and
// permutes tensors between the two VMEMs
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module simd_data_shuffler #(
    parameter int NUM_LANES = shuffle_pkg::NUM_LANES,
    parameter int DATA_W    = shuffle_pkg::DATA_W,
    parameter int ADDR_W    = shuffle_pkg::ADDR_W
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [shuffle_pkg::OPCODE_W-1:0]    opcode,
    input  logic [shuffle_pkg::FN_W-1:0]        fn,
    input  logic [shuffle_pkg::NS_ID_W-1:0]     dest_ns_id,
    input  logic [shuffle_pkg::NS_INDEX_W-1:0]  dest_ns_index_id,
    input  logic [shuffle_pkg::NS_ID_W-1:0]     src1_ns_id,
    input  logic [shuffle_pkg::NS_INDEX_W-1:0]  src1_ns_index_id,
    input  logic [shuffle_pkg::NS_ID_W-1:0]     src2_ns_id,
    input  logic [shuffle_pkg::NS_INDEX_W-1:0]  src2_ns_index_id,
    output logic                                data_shuffle_done,
    output logic [NUM_LANES-1:0]                vmem1_write_req,
    output logic [NUM_LANES-1:0][ADDR_W-1:0]    vmem1_write_addr,
    output logic [NUM_LANES-1:0][DATA_W-1:0]    vmem1_write_data,
    output logic [NUM_LANES-1:0]                vmem1_read_req,
    output logic [NUM_LANES-1:0][ADDR_W-1:0]    vmem1_read_addr,
    input  logic [NUM_LANES-1:0][DATA_W-1:0]    vmem1_read_data,
    output logic [NUM_LANES-1:0]                vmem2_write_req,
    output logic [NUM_LANES-1:0][ADDR_W-1:0]    vmem2_write_addr,
    output logic [NUM_LANES-1:0][DATA_W-1:0]    vmem2_write_data,
    output logic [NUM_LANES-1:0]                vmem2_read_req,
    output logic [NUM_LANES-1:0][ADDR_W-1:0]    vmem2_read_addr,
    input  logic [NUM_LANES-1:0][DATA_W-1:0]    vmem2_read_data
);
    import shuffle_pkg::*;

    walker_cfg_if rd_cfg ();
    walker_cfg_if wr_cfg ();

    logic               job_start;
    logic               rd_start;
    logic               wr_start;
    logic               wr_done;
    logic [NS_ID_W-1:0] src_mem;
    logic [NS_ID_W-1:0] dst_mem;
    logic               shuffle_mode;
    logic [ADDR_W-1:0]  rd_addr;
    logic               rd_addr_v;
    logic [ADDR_W-1:0]  wr_addr;
    logic               wr_addr_v;

    shuffle_cmd_decode shuffle_cmd_decode_i (
        .clk(clk), .reset(reset), .opcode(opcode), .fn(fn),
        .dest_ns_id(dest_ns_id), .dest_ns_index_id(dest_ns_index_id),
        .src1_ns_id(src1_ns_id), .src1_ns_index_id(src1_ns_index_id),
        .src2_ns_id(src2_ns_id), .src2_ns_index_id(src2_ns_index_id),
        .rd_cfg(rd_cfg.source), .wr_cfg(wr_cfg.source), .start(job_start),
        .src_mem(src_mem), .dst_mem(dst_mem), .shuffle_mode(shuffle_mode)
    );

    shuffle_ctrl shuffle_ctrl_i (
        .clk(clk), .reset(reset), .start(job_start), .wr_done(wr_done),
        .rd_start(rd_start), .wr_start(wr_start), .done(data_shuffle_done)
    );

    // read side walker, its done is not needed
    stride_walker #(.ADDR_W(ADDR_W)) rd_walker_i (
        .clk(clk), .reset(reset), .cfg(rd_cfg.sink), .start(rd_start),
        .addr(rd_addr), .addr_v(rd_addr_v), .done()
    );

    stride_walker #(.ADDR_W(ADDR_W)) wr_walker_i (
        .clk(clk), .reset(reset), .cfg(wr_cfg.sink), .start(wr_start),
        .addr(wr_addr), .addr_v(wr_addr_v), .done(wr_done)
    );

    bank_router #(.NUM_LANES(NUM_LANES), .DATA_W(DATA_W), .ADDR_W(ADDR_W)) bank_router_i (
        .clk(clk), .reset(reset),
        .rd_addr(rd_addr), .rd_addr_v(rd_addr_v), .wr_addr(wr_addr), .wr_addr_v(wr_addr_v),
        .src_mem(src_mem), .dst_mem(dst_mem), .shuffle_mode(shuffle_mode),
        .vmem1_read_data(vmem1_read_data), .vmem2_read_data(vmem2_read_data),
        .vmem1_read_req(vmem1_read_req), .vmem1_read_addr(vmem1_read_addr),
        .vmem2_read_req(vmem2_read_req), .vmem2_read_addr(vmem2_read_addr),
        .vmem1_write_req(vmem1_write_req), .vmem1_write_addr(vmem1_write_addr),
        .vmem1_write_data(vmem1_write_data),
        .vmem2_write_req(vmem2_write_req), .vmem2_write_addr(vmem2_write_addr),
        .vmem2_write_data(vmem2_write_data)
    );

endmodule

`default_nettype wire

/* hdl/bank_router.sv */
// ==================================================
// VMEM request router and read data lane rotation
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module bank_router #(
    parameter int NUM_LANES = shuffle_pkg::NUM_LANES,
    parameter int DATA_W    = shuffle_pkg::DATA_W,
    parameter int ADDR_W    = shuffle_pkg::ADDR_W
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [ADDR_W-1:0]                   rd_addr,
    input  logic                                rd_addr_v,
    input  logic [ADDR_W-1:0]                   wr_addr,
    input  logic                                wr_addr_v,
    input  logic [shuffle_pkg::NS_ID_W-1:0]     src_mem,
    input  logic [shuffle_pkg::NS_ID_W-1:0]     dst_mem,
    input  logic                                shuffle_mode,
    input  logic [NUM_LANES-1:0][DATA_W-1:0]    vmem1_read_data,
    input  logic [NUM_LANES-1:0][DATA_W-1:0]    vmem2_read_data,
    output logic [NUM_LANES-1:0]                vmem1_read_req,
    output logic [NUM_LANES-1:0][ADDR_W-1:0]    vmem1_read_addr,
    output logic [NUM_LANES-1:0]                vmem2_read_req,
    output logic [NUM_LANES-1:0][ADDR_W-1:0]    vmem2_read_addr,
    output logic [NUM_LANES-1:0]                vmem1_write_req,
    output logic [NUM_LANES-1:0][ADDR_W-1:0]    vmem1_write_addr,
    output logic [NUM_LANES-1:0][DATA_W-1:0]    vmem1_write_data,
    output logic [NUM_LANES-1:0]                vmem2_write_req,
    output logic [NUM_LANES-1:0][ADDR_W-1:0]    vmem2_write_addr,
    output logic [NUM_LANES-1:0][DATA_W-1:0]    vmem2_write_data
);
    import shuffle_pkg::*;

    localparam int K_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0][DATA_W-1:0] src_data;
    logic [NUM_LANES-1:0][DATA_W-1:0] wr_data;
    logic [K_W-1:0]                   elem_idx;

    // all lanes share one address per step
    assign vmem1_read_addr  = {NUM_LANES{rd_addr}};
    assign vmem2_read_addr  = {NUM_LANES{rd_addr}};
    assign vmem1_write_addr = {NUM_LANES{wr_addr}};
    assign vmem2_write_addr = {NUM_LANES{wr_addr}};
    assign vmem1_write_data = wr_data;
    assign vmem2_write_data = wr_data;

    // source select, unknown ids stay silent
    always_comb begin
        vmem1_read_req = '0;
        vmem2_read_req = '0;
        src_data       = '0;
        if (src_mem == VMEM1_ID) begin
            vmem1_read_req = {NUM_LANES{rd_addr_v}};
            src_data       = vmem1_read_data;
        end else if (src_mem == VMEM2_ID) begin
            vmem2_read_req = {NUM_LANES{rd_addr_v}};
            src_data       = vmem2_read_data;
        end
    end

    always_comb begin
        vmem1_write_req = '0;
        vmem2_write_req = '0;
        if (dst_mem == VMEM1_ID) begin
            vmem1_write_req = {NUM_LANES{wr_addr_v}};
        end else if (dst_mem == VMEM2_ID) begin
            vmem2_write_req = {NUM_LANES{wr_addr_v}};
        end
    end

    // element index, back to 0 whenever no write is in flight
    always_ff @(posedge clk) begin
        if (reset || !wr_addr_v) begin
            elem_idx <= '0;
        end else if (elem_idx == K_W'(NUM_LANES - 1)) begin
            elem_idx <= '0;
        end else begin
            elem_idx <= elem_idx + 1'b1;
        end
    end

    // lane n takes source lane (n + k) mod lanes when shuffling
    always_comb begin
        for (int n = 0; n < NUM_LANES; n++) begin
            if (shuffle_mode) begin
                wr_data[n] = src_data[(n + int'(elem_idx)) % NUM_LANES];
            end else begin
                wr_data[n] = src_data[n];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/stride_walker.sv */
// ==================================================
// two-level strided address walker for one side
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module stride_walker #(
    parameter int ADDR_W = shuffle_pkg::ADDR_W
) (
    input  logic              clk,
    input  logic              reset,
    walker_cfg_if.sink        cfg,
    input  logic              start,
    output logic [ADDR_W-1:0] addr,
    output logic              addr_v,
    output logic              done
);
    import shuffle_pkg::*;

    logic [ADDR_W-1:0]                base;
    logic [NUM_LOOPS-1:0][ADDR_W-1:0] stride;
    logic [NUM_LOOPS-1:0][ITER_W-1:0] count;
    logic [NUM_LOOPS-1:0][ITER_W-1:0] idx;
    logic [NUM_LOOPS-1:0][ITER_W-1:0] idx_nxt;
    logic [NUM_LOOPS-1:0]             at_end;
    logic [ITER_W-1:0]                iter_val;
    logic [ADDR_W-1:0]                addr_sum;
    logic                             active;
    logic                             last;
    logic                             carry;

    // zero count behaves as a single pass
    assign iter_val = (cfg.value[ITER_W-1:0] == '0) ? ITER_W'(1) : cfg.value[ITER_W-1:0];

    // ==================================================
    // configuration registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            base   <= '0;
            stride <= '0;
            for (int l = 0; l < NUM_LOOPS; l++) begin
                count[l] <= ITER_W'(1);
            end
        end else begin
            if (cfg.base_v) begin
                base <= cfg.value[ADDR_W-1:0];
            end
            if (cfg.stride_v) begin
                stride[cfg.loop_id] <= cfg.value[ADDR_W-1:0];
            end
            if (cfg.iter_v) begin
                count[cfg.loop_id] <= iter_val;
            end
        end
    end

    // ==================================================
    // loop counters, inner loop carries into outer
    // ==================================================
    always_comb begin
        carry = 1'b1;
        for (int l = 0; l < NUM_LOOPS; l++) begin
            at_end[l]  = (idx[l] == count[l] - 1'b1);
            idx_nxt[l] = idx[l];
            if (carry) begin
                if (at_end[l]) begin
                    idx_nxt[l] = '0;
                end else begin
                    idx_nxt[l] = idx[l] + 1'b1;
                    carry      = 1'b0;
                end
            end
        end
    end

    assign last = &at_end;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (start) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (active) begin
            idx <= idx_nxt;
            if (last) begin
                active <= 1'b0;
            end
        end
    end

    // base + sum of index times stride
    always_comb begin
        addr_sum = base;
        for (int l = 0; l < NUM_LOOPS; l++) begin
            addr_sum = addr_sum + ADDR_W'(idx[l]) * stride[l];
        end
    end

    assign addr   = addr_sum;
    assign addr_v = active;
    assign done   = active && last;

endmodule

`default_nettype wire

/* hdl/shuffle_ctrl.sv */
// ==================================================
// job controller: staggers walker starts and
// raises done once the write side has finished
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module shuffle_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic wr_done,
    output logic rd_start,
    output logic wr_start,
    output logic done
);
    import shuffle_pkg::*;

    state_e state;
    state_e state_nxt;
    logic   accept;

    // a start outside idle is dropped
    assign accept = start && (state == ST_IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (wr_done) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            state    <= state_nxt;
            // read walker one cycle behind start, write walker one more
            rd_start <= accept;
            wr_start <= rd_start;
        end
    end

    assign done = (state == ST_DONE);

endmodule

`default_nettype wire

/* hdl/shuffle_cmd_decode.sv */
// ==================================================
// permute instruction decoder: walker config strobes
// and job fields latched at start
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module shuffle_cmd_decode (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [shuffle_pkg::OPCODE_W-1:0]  opcode,
    input  logic [shuffle_pkg::FN_W-1:0]      fn,
    input  logic [shuffle_pkg::NS_ID_W-1:0]   dest_ns_id,
    input  logic [shuffle_pkg::NS_INDEX_W-1:0] dest_ns_index_id,
    input  logic [shuffle_pkg::NS_ID_W-1:0]   src1_ns_id,
    input  logic [shuffle_pkg::NS_INDEX_W-1:0] src1_ns_index_id,
    input  logic [shuffle_pkg::NS_ID_W-1:0]   src2_ns_id,
    input  logic [shuffle_pkg::NS_INDEX_W-1:0] src2_ns_index_id,
    walker_cfg_if.source                      rd_cfg,
    walker_cfg_if.source                      wr_cfg,
    output logic                              start,
    output logic [shuffle_pkg::NS_ID_W-1:0]   src_mem,
    output logic [shuffle_pkg::NS_ID_W-1:0]   dst_mem,
    output logic                              shuffle_mode
);
    import shuffle_pkg::*;

    logic             is_perm;
    logic             to_wr;
    logic [CFG_W-1:0] cfg_value;

    assign is_perm   = (opcode == OP_PERMUTE);
    // side select, 0 read source and 1 write destination
    assign to_wr     = dest_ns_id[0];
    assign cfg_value = {src1_ns_id, src1_ns_index_id, src2_ns_id, src2_ns_index_id};
    assign start     = is_perm && (fn == FN_START);

    // ==================================================
    // config strobes, same cycle as the instruction
    // ==================================================
    assign rd_cfg.base_v   = is_perm && (fn == FN_SET_BASE) && !to_wr;
    assign rd_cfg.stride_v = is_perm && (fn == FN_SET_STRIDE) && !to_wr;
    assign rd_cfg.iter_v   = is_perm && (fn == FN_SET_ITER) && !to_wr;
    assign rd_cfg.loop_id  = dest_ns_index_id[0];
    assign rd_cfg.value    = cfg_value;

    assign wr_cfg.base_v   = is_perm && (fn == FN_SET_BASE) && to_wr;
    assign wr_cfg.stride_v = is_perm && (fn == FN_SET_STRIDE) && to_wr;
    assign wr_cfg.iter_v   = is_perm && (fn == FN_SET_ITER) && to_wr;
    assign wr_cfg.loop_id  = dest_ns_index_id[0];
    assign wr_cfg.value    = cfg_value;

    // ==================================================
    // job fields
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            src_mem      <= '0;
            dst_mem      <= '0;
            shuffle_mode <= 1'b0;
        end else if (start) begin
            src_mem      <= src1_ns_id;
            dst_mem      <= dest_ns_id;
            // bit 0 set selects lane rotation
            shuffle_mode <= src2_ns_index_id[0];
        end
    end

endmodule

`default_nettype wire

/* hdl/walker_cfg_if.sv */
// ==================================================
// walker configuration bus, one per read/write side
// ==================================================
`timescale 1ns/1ps
`default_nettype none

interface walker_cfg_if;
    import shuffle_pkg::*;

    // one-cycle write strobes
    logic             base_v;
    logic             stride_v;
    logic             iter_v;
    // target loop, 0 inner and 1 outer
    logic             loop_id;
    logic [CFG_W-1:0] value;

    modport source (
        output base_v, stride_v, iter_v, loop_id, value
    );

    modport sink (
        input base_v, stride_v, iter_v, loop_id, value
    );

endinterface

`default_nettype wire

/* hdl/shuffle_pkg.sv */
// ==================================================
// shuffler package: default sizes, instruction
// encodings, controller states and memory ids
// ==================================================
`default_nettype none

package shuffle_pkg;

    // default datapath sizes
    parameter int NUM_LANES = 4;
    parameter int DATA_W    = 32;
    parameter int ADDR_W    = 8;

    // instruction field widths
    parameter int OPCODE_W   = 4;
    parameter int FN_W       = 4;
    parameter int NS_ID_W    = 3;
    parameter int NS_INDEX_W = 5;

    // config value is {src1 id, src1 index, src2 id, src2 index}
    parameter int CFG_W     = 16;
    parameter int ITER_W    = 8;
    parameter int NUM_LOOPS = 2;

    // namespace ids of the two vector memories
    parameter logic [NS_ID_W-1:0] VMEM1_ID = 3'd2;
    parameter logic [NS_ID_W-1:0] VMEM2_ID = 3'd3;

    typedef enum logic [OPCODE_W-1:0] {
        OP_PERMUTE = 4'd8
    } opcode_e;

    typedef enum logic [FN_W-1:0] {
        FN_SET_BASE   = 4'd0,
        FN_SET_ITER   = 4'd1,
        FN_SET_STRIDE = 4'd2,
        FN_START      = 4'd3
    } fn_e;

    // job controller
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_BUSY = 2'd1,
        ST_DONE = 2'd2
    } state_e;

endpackage

`default_nettype wire
